/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_codec_top -o tb_codec_top
	./obj_dir/tb_codec_top > sim.log
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/apb_regs.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module apb_regs (
    input  logic                  clk_256fs,
    input  logic                  rst,
    input  codec_pkg::apb_req_t   req,
    output codec_pkg::apb_rsp_t   rsp,
    output codec_pkg::frame_t     dac_frame,
    output codec_pkg::gain_t      gains,
    output logic [`CODEC_NCH-1:0] mute,
    input  codec_pkg::frame_t     adc_frame,
    input  logic                  frame_strobe
);

    localparam logic [7:0] UNITY = 8'(1 << `CODEC_GAIN_FRAC);

    logic                  access;
    logic                  mapped;
    logic                  writable;
    logic                  wr_ok;
    logic [15:0]           frame_count;
    codec_pkg::reg_word_u  wr_word;
    codec_pkg::reg_word_u  rd_word;

    // Access phase of an APB transfer, no wait states
    assign access = req.psel & req.penable;
    assign wr_ok  = access & req.pwrite & mapped & writable;

    assign wr_word.raw = req.pwdata;

    // Address decode and read mux
    always_comb begin
        rd_word.raw = '0;
        mapped      = 1'b1;
        writable    = 1'b0;
        case (req.paddr)
            `CODEC_ADDR_CTRL: begin
                rd_word.raw = {{(32-`CODEC_NCH){1'b0}}, mute};
                writable    = 1'b1;
            end
            `CODEC_ADDR_STATUS: begin
                rd_word.raw = {16'h0000, frame_count};
            end
            `CODEC_ADDR_DAC01: begin
                rd_word.pair.even = dac_frame.ch0;
                rd_word.pair.odd  = dac_frame.ch1;
                writable          = 1'b1;
            end
            `CODEC_ADDR_DAC23: begin
                rd_word.pair.even = dac_frame.ch2;
                rd_word.pair.odd  = dac_frame.ch3;
                writable          = 1'b1;
            end
            `CODEC_ADDR_ADC01: begin
                rd_word.pair.even = adc_frame.ch0;
                rd_word.pair.odd  = adc_frame.ch1;
            end
            `CODEC_ADDR_ADC23: begin
                rd_word.pair.even = adc_frame.ch2;
                rd_word.pair.odd  = adc_frame.ch3;
            end
            `CODEC_ADDR_GAIN: begin
                rd_word.gain = gains;
                writable     = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign rsp.pready  = access;
    assign rsp.prdata  = rd_word.raw;
    // Unmapped address, or a write to a read-only register
    assign rsp.pslverr = access & (~mapped | (req.pwrite & ~writable));

    always_ff @(posedge clk_256fs) begin
        if (rst) begin
            mute        <= '0;
            dac_frame   <= '0;
            gains       <= {UNITY, UNITY, UNITY, UNITY};
            frame_count <= '0;
        end else begin
            if (frame_strobe) begin
                frame_count <= frame_count + 16'd1;
            end
            if (wr_ok) begin
                case (req.paddr)
                    `CODEC_ADDR_CTRL: mute <= req.pwdata[`CODEC_NCH-1:0];
                    `CODEC_ADDR_DAC01: begin
                        dac_frame.ch0 <= wr_word.pair.even;
                        dac_frame.ch1 <= wr_word.pair.odd;
                    end
                    `CODEC_ADDR_DAC23: begin
                        dac_frame.ch2 <= wr_word.pair.even;
                        dac_frame.ch3 <= wr_word.pair.odd;
                    end
                    `CODEC_ADDR_GAIN: gains <= wr_word.gain;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/codec_defines.svh */
`ifndef CODEC_DEFINES_SVH
`define CODEC_DEFINES_SVH

// Sample format and channel count of the TDM128 link
`define CODEC_W         16
`define CODEC_NCH       4

// Gains are unsigned fixed point, unity = 1 << CODEC_GAIN_FRAC
`define CODEC_GAIN_FRAC 6

// APB register map, byte addresses
`define CODEC_ADDR_CTRL   5'h00
`define CODEC_ADDR_STATUS 5'h04
`define CODEC_ADDR_DAC01  5'h08
`define CODEC_ADDR_DAC23  5'h0C
`define CODEC_ADDR_ADC01  5'h10
`define CODEC_ADDR_ADC23  5'h14
`define CODEC_ADDR_GAIN   5'h18

`endif

/* rtl/codec_pkg.sv */
`include "codec_defines.svh"

package codec_pkg;

    typedef logic signed [`CODEC_W-1:0] sample_t;

    // One TDM frame, ch0 sits in the low bits
    typedef struct packed {
        sample_t ch3;
        sample_t ch2;
        sample_t ch1;
        sample_t ch0;
    } frame_t;

    // Per-channel unsigned gains, g0 in the low byte
    typedef struct packed {
        logic [7:0] g3;
        logic [7:0] g2;
        logic [7:0] g1;
        logic [7:0] g0;
    } gain_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // Two samples in one bus word, odd channel on top
    typedef struct packed {
        sample_t odd;
        sample_t even;
    } sample_pair_t;

    // Register word seen either as a sample pair or as the gain set
    typedef union packed {
        sample_pair_t pair;
        gain_t        gain;
        logic [31:0]  raw;
    } reg_word_u;

endpackage

/* rtl/codec_top.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module codec_top (
    input  logic                clk_256fs,
    input  logic                rst,
    input  codec_pkg::apb_req_t apb_req,
    output codec_pkg::apb_rsp_t apb_rsp,
    output logic                pdn,
    output logic                mclk,
    output logic                bick,
    output logic                lrck,
    output logic                sdin1,
    input  logic                sdout1
);

    codec_pkg::frame_t     dac_frame;
    codec_pkg::frame_t     scaled;
    codec_pkg::frame_t     adc_frame;
    codec_pkg::gain_t      gains;
    logic [`CODEC_NCH-1:0] mute;
    logic                  frame_strobe;

    // Host side registers
    apb_regs u_regs (
        .clk_256fs    (clk_256fs),
        .rst          (rst),
        .req          (apb_req),
        .rsp          (apb_rsp),
        .dac_frame    (dac_frame),
        .gains        (gains),
        .mute         (mute),
        .adc_frame    (adc_frame),
        .frame_strobe (frame_strobe)
    );

    gain_stage u_gain (
        .clk_256fs (clk_256fs),
        .rst       (rst),
        .dac_frame (dac_frame),
        .gains     (gains),
        .mute      (mute),
        .scaled    (scaled)
    );

    // Serial link to the AK4619
    tdm_port u_tdm (
        .clk_256fs    (clk_256fs),
        .rst          (rst),
        .tx_frame     (scaled),
        .rx_frame     (adc_frame),
        .frame_strobe (frame_strobe),
        .pdn          (pdn),
        .mclk         (mclk),
        .bick         (bick),
        .lrck         (lrck),
        .sdin1        (sdin1),
        .sdout1       (sdout1)
    );

endmodule

/* rtl/gain_stage.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module gain_stage (
    input  logic                  clk_256fs,
    input  logic                  rst,
    input  codec_pkg::frame_t     dac_frame,
    input  codec_pkg::gain_t      gains,
    input  logic [`CODEC_NCH-1:0] mute,
    output codec_pkg::frame_t     scaled
);

    localparam int W    = `CODEC_W;
    localparam int NCH  = `CODEC_NCH;
    localparam int FRAC = `CODEC_GAIN_FRAC;

    logic [NCH-1:0][W-1:0] samples;
    logic [NCH-1:0][7:0]   gain_arr;
    logic [NCH-1:0][W-1:0] result;

    // Signed sample times unsigned gain, then clipped back to W bits
    function automatic logic [W-1:0] scale_sat(input logic signed [W-1:0] s,
                                               input logic [7:0] g);
        logic signed [W+8:0]      prod;
        logic signed [W+8-FRAC:0] shifted;
        prod    = s * $signed({1'b0, g});
        shifted = prod[W+8:FRAC];
        // Clip when any upper bit differs from the sign bit
        if (shifted[W+8-FRAC:W-1] != {(10-FRAC){shifted[W-1]}}) begin
            scale_sat = shifted[W+8-FRAC] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
        end else begin
            scale_sat = shifted[W-1:0];
        end
    endfunction

    assign samples  = dac_frame;
    assign gain_arr = gains;

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            result[i] = mute[i] ? '0 : scale_sat(samples[i], gain_arr[i]);
        end
    end

    always_ff @(posedge clk_256fs) begin
        if (rst) begin
            scaled <= '0;
        end else begin
            scaled <= result;
        end
    end

endmodule

/* rtl/tdm_port.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module tdm_port (
    input  logic              clk_256fs,
    input  logic              rst,
    input  codec_pkg::frame_t tx_frame,
    output codec_pkg::frame_t rx_frame,
    output logic              frame_strobe,
    output logic              pdn,
    output logic              mclk,
    output logic              bick,
    output logic              lrck,
    output logic              sdin1,
    input  logic              sdout1
);

    localparam int W   = `CODEC_W;
    localparam int NCH = `CODEC_NCH;
    localparam int BW  = $clog2(W);

    logic [7:0]            clkdiv;
    logic [7:0]            clkdiv_nxt;
    logic [1:0]            channel;
    logic [4:0]            bit_idx;
    logic [1:0]            nxt_channel;
    logic [4:0]            nxt_bit_idx;
    logic [BW-1:0]         tx_bit;
    logic [BW-1:0]         rx_bit;
    logic [NCH-1:0][W-1:0] tx_latch;
    logic [NCH-1:0][W-1:0] tx_src;
    logic [NCH-1:0][W-1:0] rx_words;

    // Codec clocks all come straight off the divider
    assign pdn   = ~rst;
    assign mclk  = clk_256fs;
    assign bick  = clkdiv[0];
    assign lrck  = clkdiv[7];

    assign channel    = clkdiv[7:6];
    assign bit_idx    = clkdiv[5:1];
    assign clkdiv_nxt = clkdiv + 8'd1;

    // Slot position after the coming edge, used when driving SDIN1
    assign nxt_channel = clkdiv_nxt[7:6];
    assign nxt_bit_idx = clkdiv_nxt[5:1];

    // MSB first within each slot
    assign tx_bit = BW'(W - 1) - nxt_bit_idx[BW-1:0];
    assign rx_bit = BW'(W - 1) - bit_idx[BW-1:0];

    assign frame_strobe = (clkdiv == 8'hFF);

    // At the strobe the first bit of the next frame comes from the new frame,
    // the latch only catches up on the same edge
    assign tx_src = frame_strobe ? tx_frame : tx_latch;

    always_ff @(posedge clk_256fs) begin
        if (rst) begin
            clkdiv   <= '0;
            sdin1    <= 1'b0;
            rx_frame <= '0;
        end else begin
            clkdiv <= clkdiv_nxt;

            // BICK about to fall, present the next data bit
            if (bick) begin
                if (nxt_bit_idx < 5'(W)) begin
                    sdin1 <= tx_src[nxt_channel][tx_bit];
                end else begin
                    sdin1 <= 1'b0;
                end
            end

            // Publish the words gathered over the frame that is ending
            if (frame_strobe) begin
                rx_frame <= rx_words;
            end
        end
    end

    always_ff @(posedge clk_256fs) begin
        if (frame_strobe) begin
            tx_latch <= tx_frame;
        end

        // BICK about to rise, sample the codec output
        if (!bick && bit_idx < 5'(W)) begin
            rx_words[channel][rx_bit] <= sdout1;
        end
    end

endmodule

/* src.f */
+incdir+rtl
rtl/codec_pkg.sv
rtl/tdm_port.sv
rtl/gain_stage.sv
rtl/apb_regs.sv
rtl/codec_top.sv
tests/tb_codec_top.sv

/* tests/tb_codec_top.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module tb_codec_top;

    localparam int TIMEOUT_CYCLES = 20 * 256 + 1000;

    logic                clk_256fs;
    logic                rst;
    codec_pkg::apb_req_t apb_req;
    codec_pkg::apb_rsp_t apb_rsp;
    logic                pdn;
    logic                mclk;
    logic                bick;
    logic                lrck;
    logic                sdin1;
    logic                sdout1 = 1'b0;

    // Codec model state
    logic [7:0]       pos;
    logic [7:0]       nxt;
    logic             prev_lrck;
    logic             synced;
    logic [3:0][15:0] cap;
    logic [3:0][15:0] cur_adc;
    logic [3:0][15:0] next_adc;
    logic [3:0][15:0] last_cap;
    int               cap_count;
    int               lrck_falls;
    int               cycles;
    int               test_errs = 0;
    int               passes = 0;
    int               fails = 0;

    codec_top UUT (
        .clk_256fs (clk_256fs),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pdn       (pdn),
        .mclk      (mclk),
        .bick      (bick),
        .lrck      (lrck),
        .sdin1     (sdin1),
        .sdout1    (sdout1)
    );

    initial begin
        clk_256fs = 1'b0;
        forever #2 clk_256fs = ~clk_256fs;
    end

    // Expected DAC sample after gain, saturation and mute
    function automatic logic [15:0] expected_sample(input logic [15:0] s, input logic [7:0] g,
                                                    input logic m);
        int p;
        p = (int'($signed(s)) * int'(g)) >>> `CODEC_GAIN_FRAC;
        if (m) begin
            return 16'h0000;
        end
        if (p > 32767) begin
            p = 32767;
        end else if (p < -32768) begin
            p = -32768;
        end
        return 16'(p);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            passes++;
            $display("%s: passed", name);
        end else begin
            fails++;
            $display("%s: failed with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic apb_access(input logic write, input logic [4:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk_256fs);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk_256fs);
        if (apb_rsp.pready !== 1'b0) begin
            $display("APB access to address %h saw pready high in the setup phase", addr);
            test_errs++;
        end
        apb_req.penable <= 1'b1;
        @(posedge clk_256fs);
        // Access phase ends on this edge
        if (apb_rsp.pready !== 1'b1) begin
            $display("APB access to address %h saw pready low in the access phase", addr);
            test_errs++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic wait_captures(input int n);
        int start;
        start = cap_count;
        while (cap_count < start + n) begin
            @(posedge clk_256fs);
        end
    endtask

    task automatic send_and_compare(input string name, input logic [3:0][15:0] samp,
                                    input logic [3:0][7:0] gain, input logic [3:0] mute);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, `CODEC_ADDR_GAIN, gain, rd, err);
        apb_access(1'b1, `CODEC_ADDR_CTRL, 32'(mute), rd, err);
        apb_access(1'b1, `CODEC_ADDR_DAC01, {samp[1], samp[0]}, rd, err);
        apb_access(1'b1, `CODEC_ADDR_DAC23, {samp[3], samp[2]}, rd, err);
        // Gain stage adds a cycle before a strobe can latch the new frame
        repeat (2) @(posedge clk_256fs);
        wait_captures(2);
        for (int i = 0; i < 4; i++) begin
            check($sformatf("%s_ch%0d", name, i),
                  32'(expected_sample(samp[i], gain[i], mute[i])), 32'(last_cap[i]));
        end
        finish_test(name);
    endtask

    // Codec model follows the frame from LRCK, reads SDIN1 and drives SDOUT1
    always @(posedge clk_256fs) begin
        if (rst) begin
            synced     = 1'b0;
            prev_lrck  = 1'b0;
            pos        = 8'd0;
            cur_adc    = '0;
            cap        = '0;
            sdout1     <= 1'b0;
            cap_count  <= 0;
            lrck_falls <= 0;
        end else begin
            if (prev_lrck && !lrck) begin
                synced     = 1'b1;
                pos        = 8'd0;
                lrck_falls <= lrck_falls + 1;
            end else begin
                pos = pos + 8'd1;
            end
            prev_lrck = lrck;
            // BICK is high here and falls on this edge
            if (synced && bick) begin
                if (!pos[5]) begin
                    cap[pos[7:6]][~pos[4:1]] = sdin1;
                end
                if (pos == 8'hFF) begin
                    last_cap  <= cap;
                    cap_count <= cap_count + 1;
                    cur_adc   = next_adc;
                end
                nxt = pos + 8'd1;
                sdout1 <= nxt[5] ? 1'b0 : cur_adc[nxt[7:6]][~nxt[4:1]];
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_256fs);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0]      rd;
        logic [31:0]      wdata;
        logic             err;
        logic [3:0][15:0] samp;
        logic [3:0][7:0]  gain;
        logic [15:0]      status0;
        int               falls0;
        int               diff;

        void'($urandom(6479));
        rst      = 1'b1;
        apb_req  = '0;
        next_adc = '0;

        for (int i = 0; i < 16; i++) begin
            @(posedge clk_256fs);
            if (i == 8) begin
                check("reset_pdn", 32'(0), 32'(pdn));
                check("reset_sdin1", 32'(0), 32'(sdin1));
            end
        end
        rst <= 1'b0;
        apb_access(1'b0, `CODEC_ADDR_GAIN, 32'h0, rd, err);
        check("reset_gain", {4{8'(1 << `CODEC_GAIN_FRAC)}}, rd);
        check("reset_gain_pslverr", 32'(0), 32'(err));
        apb_access(1'b0, `CODEC_ADDR_CTRL, 32'h0, rd, err);
        check("reset_ctrl", 32'h0, rd);
        apb_access(1'b0, `CODEC_ADDR_DAC01, 32'h0, rd, err);
        check("reset_dac01", 32'h0, rd);
        apb_access(1'b0, `CODEC_ADDR_ADC01, 32'h0, rd, err);
        check("reset_adc01", 32'h0, rd);
        check("pdn_released", 32'(1), 32'(pdn));
        // MCLK follows the master clock
        #1;
        check("mclk_high", 32'(1), 32'(mclk));
        @(negedge clk_256fs);
        #1;
        check("mclk_low", 32'(0), 32'(mclk));
        finish_test("reset_state");

        wdata = $urandom;
        apb_access(1'b1, `CODEC_ADDR_DAC01, wdata, rd, err);
        check("rw_dac01_pslverr", 32'(0), 32'(err));
        apb_access(1'b0, `CODEC_ADDR_DAC01, 32'h0, rd, err);
        check("rw_dac01", wdata, rd);
        wdata = $urandom;
        apb_access(1'b1, `CODEC_ADDR_DAC23, wdata, rd, err);
        apb_access(1'b0, `CODEC_ADDR_DAC23, 32'h0, rd, err);
        check("rw_dac23", wdata, rd);
        wdata = $urandom;
        apb_access(1'b1, `CODEC_ADDR_GAIN, wdata, rd, err);
        apb_access(1'b0, `CODEC_ADDR_GAIN, 32'h0, rd, err);
        check("rw_gain", wdata, rd);
        apb_access(1'b0, 5'h1C, 32'h0, rd, err);
        check("unmapped_data", 32'h0, rd);
        check("unmapped_pslverr", 32'(1), 32'(err));
        apb_access(1'b0, `CODEC_ADDR_STATUS, 32'h0, rd, err);
        status0 = rd[15:0];
        apb_access(1'b1, `CODEC_ADDR_STATUS, 32'h0000BEEF, rd, err);
        check("status_write_pslverr", 32'(1), 32'(err));
        apb_access(1'b0, `CODEC_ADDR_STATUS, 32'h0, rd, err);
        check("status_unchanged", 32'(1), 32'(16'(rd[15:0] - status0) <= 16'd1));
        finish_test("register_access");

        for (int i = 0; i < 4; i++) begin
            samp[i] = 16'($urandom);
        end
        send_and_compare("dac_unity", samp, {4{8'(1 << `CODEC_GAIN_FRAC)}}, 4'h0);

        // Large samples on ch0 and ch1 so the high gains clip both ways
        samp[0] = 16'h6000 | 16'($urandom_range(0, 16'h1FFF));
        samp[1] = 16'h8000 | 16'($urandom_range(0, 16'h1FFF));
        samp[2] = 16'($urandom);
        samp[3] = 16'($urandom);
        gain    = {8'($urandom_range(0, 255)), 8'($urandom_range(0, 255)),
                   8'($urandom_range(128, 255)), 8'hFF};
        send_and_compare("gain_mute", samp, gain, 4'b0100);

        for (int i = 0; i < 4; i++) begin
            next_adc[i] <= 16'($urandom);
        end
        @(posedge clk_256fs);
        wait_captures(2);
        apb_access(1'b0, `CODEC_ADDR_ADC01, 32'h0, rd, err);
        check("adc01", {next_adc[1], next_adc[0]}, rd);
        apb_access(1'b0, `CODEC_ADDR_ADC23, 32'h0, rd, err);
        check("adc23", {next_adc[3], next_adc[2]}, rd);
        apb_access(1'b0, `CODEC_ADDR_STATUS, 32'h0, rd, err);
        status0 = rd[15:0];
        falls0  = lrck_falls;
        while (lrck_falls < falls0 + 3) begin
            @(posedge clk_256fs);
        end
        apb_access(1'b0, `CODEC_ADDR_STATUS, 32'h0, rd, err);
        diff = int'(16'(rd[15:0] - status0)) - (lrck_falls - falls0);
        check("frame_count", 32'(1), 32'(diff >= -1 && diff <= 1));
        finish_test("adc_and_frame_count");

        $display("Tests passed: %0d, failed: %0d", passes, fails);
        if (fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
